/* Makefile */
# Verilator build and run for dm_lite
VERILATOR ?= verilator
TOP       ?= dm_lite_tb
FILELIST  ?= dm_lite.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || grep -q "%Error" $(LOG) || \
	    ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation FAILED, see $(LOG)"; exit 1; \
	else \
	  echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/dm_control_regs.sv */
// ----------------------------------------------------------------------
// dmcontrol/dmstatus for one modelled hart. Writing dmactive 0 resets all
// run-control state; haltreq wins over resumereq in the same write
// ----------------------------------------------------------------------
`default_nettype none

module dm_control_regs (
  input  logic                     clk,
  input  logic                     reset,
  input  dm_lite_pkg::dmi_req_t    dmi_req,
  input  logic                     dmi_req_valid,
  output dm_lite_pkg::blk_result_t result
);

  dm_lite_pkg::dmi_word_u  wdata;
  dm_lite_pkg::dmcontrol_t dmcontrol_q;
  dm_lite_pkg::dmstatus_t  dmstatus;
  logic                    halted_q;     // hart model: 1 halted, 0 running
  logic                    resumeack_q;
  logic                    sel_ctrl;
  logic                    sel_stat;
  logic                    ctrl_we;

  // ------------------------------------------------------------------
  // decode
  // ------------------------------------------------------------------
  assign wdata.raw = dmi_req.data;

  assign sel_ctrl = (dmi_req.addr == dm_lite_pkg::addr_dmcontrol);
  assign sel_stat = (dmi_req.addr == dm_lite_pkg::addr_dmstatus);

  assign result.hit  = dmi_req_valid && (sel_ctrl || sel_stat);
  assign result.busy = 1'b0; // run control answers at once

  assign ctrl_we = dmi_req_valid && sel_ctrl && !result.busy &&
                   (dmi_req.op == dm_lite_pkg::dmi_write);

  always_comb begin
    dmstatus              = '0;
    dmstatus.allresumeack = resumeack_q;
    dmstatus.allrunning   = !halted_q;
    dmstatus.allhalted    = halted_q;
    dmstatus.version      = dm_lite_pkg::dm_version;
  end

  always_comb begin
    if (sel_ctrl) begin
      result.rdata = dmcontrol_q;
    end else begin
      result.rdata = dmstatus;
    end
  end

  // ------------------------------------------------------------------
  // register and hart state
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      dmcontrol_q <= '0;
      halted_q    <= 1'b0;
      resumeack_q <= 1'b0;
    end else if (ctrl_we) begin
      if (!wdata.ctrl.dmactive) begin
        dmcontrol_q <= '0;  // module goes inactive
        halted_q    <= 1'b0;
        resumeack_q <= 1'b0;
      end else begin
        // resumereq is write-only and reads back 0
        dmcontrol_q <= '{haltreq: wdata.ctrl.haltreq, dmactive: 1'b1, default: '0};
        if (wdata.ctrl.haltreq) begin
          halted_q    <= 1'b1;
          resumeack_q <= 1'b0;
        end else if (wdata.ctrl.resumereq) begin
          halted_q    <= 1'b0;
          resumeack_q <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/dm_lite_pkg.sv */
// ----------------------------------------------------------------------
// DMI, SBA bus and register types for dm_lite. Single hart and 32-bit
// system bus accesses only, so the widths follow the debug spec
// ----------------------------------------------------------------------
`default_nettype none

package dm_lite_pkg;

  // ------------------------------------------------------------------
  // DMI transport
  // ------------------------------------------------------------------
  // the request and response ops share one 2-bit encoding
  typedef enum logic [1:0] {
    dmi_nop   = 2'd0,
    dmi_read  = 2'd1,
    dmi_write = 2'd2,
    dmi_busy  = 2'd3
  } dmi_op_e;

  localparam dmi_op_e dmi_success = dmi_nop;   // response view of op 0
  localparam dmi_op_e dmi_failed  = dmi_write; // response view of op 2

  typedef struct packed {
    logic [6:0]  addr;
    logic [31:0] data;
    dmi_op_e     op;
  } dmi_req_t;

  typedef struct packed {
    logic [31:0] data;
    dmi_op_e     op;
  } dmi_resp_t;

  // ------------------------------------------------------------------
  // debug registers, bit positions as in the debug spec
  // ------------------------------------------------------------------
  typedef struct packed {
    logic        haltreq;      // 31
    logic        resumereq;    // 30
    logic [28:0] rsvd;
    logic        dmactive;     // 0
  } dmcontrol_t;

  typedef struct packed {
    logic [13:0] rsvd_hi;
    logic        allresumeack; // 17
    logic [4:0]  rsvd_mid;
    logic        allrunning;   // 11
    logic        rsvd_run;
    logic        allhalted;    // 9
    logic [4:0]  rsvd_lo;
    logic [3:0]  version;
  } dmstatus_t;

  typedef struct packed {
    logic [8:0]  rsvd_hi;
    logic        sbbusyerror;     // 22, write 1 to clear
    logic        sbbusy;          // 21
    logic        sbreadonaddr;    // 20
    logic [2:0]  sbaccess;        // 19:17
    logic        sbautoincrement; // 16
    logic        rsvd_rod;        // no read-on-data
    logic [2:0]  sberror;         // 14:12
    logic [11:0] rsvd_lo;
  } sbcs_t;

  // one DMI data word, decoded by whichever block owns the address
  typedef union packed {
    dmcontrol_t  ctrl;
    sbcs_t       sbcs;
    logic [31:0] raw;
  } dmi_word_u;

  // per-block answer to a request
  typedef struct packed {
    logic        hit;
    logic        busy;
    logic [31:0] rdata;
  } blk_result_t;

  // word request to the system bus memory
  typedef struct packed {
    logic        valid;
    logic        we;
    logic [29:0] addr;  // word address
    logic [31:0] wdata;
  } sb_req_t;

  // ------------------------------------------------------------------
  // addresses and constants
  // ------------------------------------------------------------------
  localparam logic [6:0] addr_dmcontrol  = 7'h10;
  localparam logic [6:0] addr_dmstatus   = 7'h11;
  localparam logic [6:0] addr_sbcs       = 7'h38;
  localparam logic [6:0] addr_sbaddress0 = 7'h39;
  localparam logic [6:0] addr_sbdata0    = 7'h3C;

  localparam logic [3:0] dm_version  = 4'd2;  // debug spec 0.13
  localparam logic [2:0] sbaccess_32 = 3'd2;

  localparam int unsigned sba_busy_cycles = 3;
  localparam int unsigned sba_cnt_bits    = $clog2(sba_busy_cycles + 1);

  localparam int unsigned ram_words     = 256;
  localparam int unsigned ram_addr_bits = $clog2(ram_words);

endpackage

`default_nettype wire

/* design/dm_lite_top.sv */
// ----------------------------------------------------------------------
// dm_lite top. No back-pressure: one request per response, fixed latency
// ----------------------------------------------------------------------
`default_nettype none

module dm_lite_top (
  input  logic                   clk,
  input  logic                   reset,
  input  dm_lite_pkg::dmi_req_t  dmi_req,
  input  logic                   dmi_req_valid,
  output dm_lite_pkg::dmi_resp_t dmi_resp,
  output logic                   dmi_resp_valid
);

  dm_lite_pkg::blk_result_t ctrl_result;
  dm_lite_pkg::blk_result_t sba_result;
  dm_lite_pkg::sb_req_t     sb_req;
  logic [31:0]              sb_rdata;

  // run control
  dm_control_regs u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .dmi_req       (dmi_req),
    .dmi_req_valid (dmi_req_valid),
    .result        (ctrl_result)
  );

  // system bus access and its memory
  sba_engine u_sba (
    .clk           (clk),
    .reset         (reset),
    .dmi_req       (dmi_req),
    .dmi_req_valid (dmi_req_valid),
    .result        (sba_result),
    .sb_req        (sb_req),
    .sb_rdata      (sb_rdata)
  );

  sys_ram u_ram (
    .clk      (clk),
    .sb_req   (sb_req),
    .sb_rdata (sb_rdata)
  );

  dmi_response_mux u_resp (
    .clk            (clk),
    .reset          (reset),
    .dmi_req_valid  (dmi_req_valid),
    .ctrl_result    (ctrl_result),
    .sba_result     (sba_result),
    .dmi_resp       (dmi_resp),
    .dmi_resp_valid (dmi_resp_valid)
  );

endmodule

`default_nettype wire

/* design/dmi_response_mux.sv */
// ----------------------------------------------------------------------
// merges block results into one registered DMI response, one cycle late
// ----------------------------------------------------------------------
`default_nettype none

module dmi_response_mux (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     dmi_req_valid,
  input  dm_lite_pkg::blk_result_t ctrl_result,
  input  dm_lite_pkg::blk_result_t sba_result,
  output dm_lite_pkg::dmi_resp_t   dmi_resp,
  output logic                     dmi_resp_valid
);

  dm_lite_pkg::blk_result_t sel;
  dm_lite_pkg::dmi_resp_t   resp_d;

  // address ranges are disjoint, at most one block hits
  assign sel = ctrl_result.hit ? ctrl_result : sba_result;

  always_comb begin
    resp_d = '0;
    if (!ctrl_result.hit && !sba_result.hit) begin
      resp_d.op = dm_lite_pkg::dmi_failed;  // unmapped
    end else if (sel.busy) begin
      resp_d.op = dm_lite_pkg::dmi_busy;
    end else begin
      resp_d.op   = dm_lite_pkg::dmi_success;
      resp_d.data = sel.rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dmi_resp_valid <= 1'b0;
    end else begin
      dmi_resp_valid <= dmi_req_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dmi_req_valid) begin
      dmi_resp <= resp_d;
    end
  end

endmodule

`default_nettype wire

/* design/sba_engine.sv */
// ----------------------------------------------------------------------
// SBA engine, 32-bit accesses only. No read-on-data; sbaddress0/sbdata0
// touched while sbbusy answers busy and sets sbbusyerror
// ----------------------------------------------------------------------
`default_nettype none

module sba_engine (
  input  logic                     clk,
  input  logic                     reset,
  input  dm_lite_pkg::dmi_req_t    dmi_req,
  input  logic                     dmi_req_valid,
  output dm_lite_pkg::blk_result_t result,
  output dm_lite_pkg::sb_req_t     sb_req,
  input  logic [31:0]              sb_rdata
);

  dm_lite_pkg::dmi_word_u wdata;
  dm_lite_pkg::sbcs_t     sbcs;

  logic [dm_lite_pkg::sba_cnt_bits-1:0] cnt_q;  // cycles left in access
  logic        sbbusyerror_q;
  logic        sbreadonaddr_q;
  logic        sbautoincrement_q;
  logic [31:0] sbaddress0_q;
  logic [31:0] sbdata0_q;
  logic        acc_we_q;      // current access is a write

  logic sel_sbcs;
  logic sel_addr;
  logic sel_data;
  logic sbbusy;
  logic wr_ok;
  logic start_rd;
  logic start_wr;
  logic capture;
  logic complete;

  // ------------------------------------------------------------------
  // decode and response
  // ------------------------------------------------------------------
  assign wdata.raw = dmi_req.data;

  assign sel_sbcs = (dmi_req.addr == dm_lite_pkg::addr_sbcs);
  assign sel_addr = (dmi_req.addr == dm_lite_pkg::addr_sbaddress0);
  assign sel_data = (dmi_req.addr == dm_lite_pkg::addr_sbdata0);

  assign sbbusy = (cnt_q != '0);

  assign result.hit  = dmi_req_valid && (sel_sbcs || sel_addr || sel_data);
  assign result.busy = (sel_addr || sel_data) && sbbusy; // sbcs stays pollable

  assign wr_ok    = dmi_req_valid && !result.busy && (dmi_req.op == dm_lite_pkg::dmi_write);
  assign start_wr = wr_ok && sel_data;
  assign start_rd = wr_ok && sel_addr && sbreadonaddr_q;

  // read data arrives one cycle after the bus request
  assign capture  = !acc_we_q &&
                    (cnt_q == dm_lite_pkg::sba_cnt_bits'(dm_lite_pkg::sba_busy_cycles - 1));
  assign complete = (cnt_q == dm_lite_pkg::sba_cnt_bits'(1));

  always_comb begin
    sbcs                 = '0;
    sbcs.sbbusyerror     = sbbusyerror_q;
    sbcs.sbbusy          = sbbusy;
    sbcs.sbreadonaddr    = sbreadonaddr_q;
    sbcs.sbaccess        = dm_lite_pkg::sbaccess_32;  // fixed
    sbcs.sbautoincrement = sbautoincrement_q;
    sbcs.sberror         = 3'd0;  // word memory never faults
  end

  always_comb begin
    if (sel_sbcs) begin
      result.rdata = sbcs;
    end else if (sel_addr) begin
      result.rdata = sbaddress0_q;
    end else begin
      result.rdata = sbdata0_q;
    end
  end

  // ------------------------------------------------------------------
  // bus request, issued in the first busy cycle
  // ------------------------------------------------------------------
  assign sb_req.valid = (cnt_q == dm_lite_pkg::sba_cnt_bits'(dm_lite_pkg::sba_busy_cycles));
  assign sb_req.we    = acc_we_q;
  assign sb_req.addr  = sbaddress0_q[31:2];
  assign sb_req.wdata = sbdata0_q;

  // ------------------------------------------------------------------
  // control state
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_q             <= '0;
      sbbusyerror_q     <= 1'b0;
      sbreadonaddr_q    <= 1'b0;
      sbautoincrement_q <= 1'b0;
      sbaddress0_q      <= '0;
    end else begin
      if (start_rd || start_wr) begin
        cnt_q <= dm_lite_pkg::sba_cnt_bits'(dm_lite_pkg::sba_busy_cycles);
      end else if (sbbusy) begin
        cnt_q <= cnt_q - 1'b1;
      end

      if (dmi_req_valid && result.busy) begin
        sbbusyerror_q <= 1'b1;  // sticky
      end else if (wr_ok && sel_sbcs && wdata.sbcs.sbbusyerror) begin
        sbbusyerror_q <= 1'b0;
      end

      if (wr_ok && sel_sbcs) begin
        sbreadonaddr_q    <= wdata.sbcs.sbreadonaddr;
        sbautoincrement_q <= wdata.sbcs.sbautoincrement;
      end

      if (wr_ok && sel_addr) begin
        sbaddress0_q <= wdata.raw;
      end else if (complete && sbautoincrement_q) begin
        sbaddress0_q <= sbaddress0_q + 32'd4;
      end
    end
  end

  // data path
  always_ff @(posedge clk) begin
    if (start_rd || start_wr) begin
      acc_we_q <= start_wr;
    end
    if (start_wr) begin
      sbdata0_q <= wdata.raw;
    end else if (capture) begin
      sbdata0_q <= sb_rdata;
    end
  end

endmodule

`default_nettype wire

/* design/sys_ram.sv */
// ----------------------------------------------------------------------
// word RAM, one cycle read latency. Address wraps modulo ram_words and
// contents start undefined
// ----------------------------------------------------------------------
`default_nettype none

module sys_ram (
  input  logic                 clk,
  input  dm_lite_pkg::sb_req_t sb_req,
  output logic [31:0]          sb_rdata
);

  logic [31:0]                           mem [dm_lite_pkg::ram_words];
  logic [dm_lite_pkg::ram_addr_bits-1:0] idx;

  assign idx = sb_req.addr[dm_lite_pkg::ram_addr_bits-1:0];  // upper bits dropped

  // ------------------------------------------------------------------
  // single port, write or registered read
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (sb_req.valid) begin
      if (sb_req.we) begin
        mem[idx] <= sb_req.wdata;
      end else begin
        sb_rdata <= mem[idx];  // held until the next read
      end
    end
  end

endmodule

`default_nettype wire

/* dm_lite.f */
design/dm_lite_pkg.sv
design/dm_control_regs.sv
design/sba_engine.sv
design/sys_ram.sv
design/dmi_response_mux.sv
design/dm_lite_top.sv
testbench/dm_lite_checker.sv
testbench/dm_lite_assert.sv
testbench/dm_lite_tb.sv

/* testbench/dm_lite_assert.sv */
// ----------------------------------------------------------------------
// pulse timing checks, bound to the response mux and the SBA engine
// ----------------------------------------------------------------------
`default_nettype none

module dm_lite_assert (
  input logic clk,
  input logic reset,
  input logic cause,   // must be answered one cycle later
  input logic pulse,   // the one-cycle answer
  input logic window   // pulse only in the first cycle of this
);

  a_answer: assert property (@(posedge clk) disable iff (reset) cause |=> pulse)
    else $error("no pulse in the cycle after its cause");

  a_window: assert property (@(posedge clk) disable iff (reset) pulse |-> $rose(window))
    else $error("pulse outside the first cycle of its window");

endmodule

// response one cycle after each request, never two in a row
bind dmi_response_mux dm_lite_assert u_resp_assert (
  .clk    (clk),
  .reset  (reset),
  .cause  (dmi_req_valid),
  .pulse  (dmi_resp_valid),
  .window (dmi_resp_valid)  // its own window, so it must rise each time
);

// bus request opens the busy window
bind sba_engine dm_lite_assert u_bus_assert (
  .clk    (clk),
  .reset  (reset),
  .cause  (start_rd || start_wr),
  .pulse  (sb_req.valid),
  .window (sbbusy)
);

`default_nettype wire

/* testbench/dm_lite_checker.sv */
// ----------------------------------------------------------------------
// compares each DMI response with the expectation latched with its
// request; requests issued with exp_en low are not checked
// ----------------------------------------------------------------------
`default_nettype none

module dm_lite_checker (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   dmi_req_valid,
  input  dm_lite_pkg::dmi_resp_t dmi_resp,
  input  logic                   dmi_resp_valid,
  input  logic                   exp_en,
  input  int                     exp_id,
  input  logic [15:0]            exp_step,
  input  dm_lite_pkg::dmi_op_e   exp_op,
  input  logic [31:0]            exp_data,
  input  logic [31:0]            exp_mask,
  output int                     check_count,
  output int                     fail_count
);

  logic                 pend_en;
  int                   pend_id;
  logic [15:0]          pend_step;
  dm_lite_pkg::dmi_op_e pend_op;
  logic [31:0]          pend_data;
  logic [31:0]          pend_mask;
  int                   checks = 0;
  int                   fails = 0;

  assign check_count = checks;
  assign fail_count  = fails;

  // expectation travels with the request strobe
  always @(posedge clk) begin
    if (reset) begin
      pend_en <= 1'b0;
    end else if (dmi_req_valid) begin
      pend_en   <= exp_en;
      pend_id   <= exp_id;
      pend_step <= exp_step;
      pend_op   <= exp_op;
      pend_data <= exp_data;
      pend_mask <= exp_mask;
    end
  end

  // ------------------------------------------------------------------
  // compare on the falling edge, response is stable there
  // ------------------------------------------------------------------
  always @(negedge clk) begin
    logic op_ok;
    logic data_ok;
    if (dmi_resp_valid && pend_en) begin
      checks++;
      op_ok   = (dmi_resp.op == pend_op);
      data_ok = (((dmi_resp.data ^ pend_data) & pend_mask) == 32'd0);
      if (op_ok && data_ok) begin
        $display("test %0d step %0d: pass", pend_id, pend_step);
      end else begin
        fails++;
        $display("CHECK FAILED at %0t: test %0d step %0d got op %0d data %h, %s",
                 $time, pend_id, pend_step, dmi_resp.op, dmi_resp.data, "expected");
        $display("  op %0d data %h under mask %h", pend_op, pend_data, pend_mask);
        $display("test %0d step %0d: fail", pend_id, pend_step);
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/dm_lite_tb.sv */
// ----------------------------------------------------------------------
// dm_lite testbench. One request at a time, inputs change on the
// falling edge; SBA steps may poll sbcs until sbbusy clears
// ----------------------------------------------------------------------
`default_nettype none

module dm_lite_tb;

  localparam int clk_period   = 40;
  localparam int resp_timeout = 20;  // cycles per response
  localparam int poll_limit   = 16;  // sbcs reads per poll
  localparam int rand_seed    = 2;

  // field positions from the debug spec
  localparam logic [31:0] ctrl_haltreq   = 32'h8000_0000;
  localparam logic [31:0] ctrl_resumereq = 32'h4000_0000;
  localparam logic [31:0] ctrl_dmactive  = 32'h0000_0001;
  localparam logic [31:0] stat_resumeack = 32'h0002_0000;
  localparam logic [31:0] stat_running   = 32'h0000_0800;
  localparam logic [31:0] stat_halted    = 32'h0000_0200;
  localparam logic [31:0] stat_version   = 32'h0000_0002;
  localparam logic [31:0] sb_busyerror   = 32'h0040_0000;
  localparam logic [31:0] sb_busy        = 32'h0020_0000;
  localparam logic [31:0] sb_readonaddr  = 32'h0010_0000;
  localparam logic [31:0] sb_access32    = 32'h0004_0000;
  localparam logic [31:0] sb_autoinc     = 32'h0001_0000;
  localparam logic [6:0]  addr_unmapped  = 7'h20;

  // one row of the stimulus table
  typedef struct packed {
    int                    id;
    dm_lite_pkg::dmi_req_t req;
    dm_lite_pkg::dmi_op_e  exp_op;
    logic [31:0]           exp_data;
    logic [31:0]           mask;
    logic                  poll;      // wait for sbbusy 0 afterwards
  } step_t;

  logic                   clk;
  logic                   reset;
  dm_lite_pkg::dmi_req_t  dmi_req;
  logic                   dmi_req_valid;
  dm_lite_pkg::dmi_resp_t dmi_resp;
  logic                   dmi_resp_valid;

  logic                 exp_en;
  int                   exp_id;
  logic [15:0]          exp_step;
  dm_lite_pkg::dmi_op_e exp_op;
  logic [31:0]          exp_data;
  logic [31:0]          exp_mask;
  int                   check_count;
  int                   fail_count;

  step_t       steps[$];
  logic [31:0] words[7];   // random data for the SBA tests
  int          timeouts;
  int          stalls;

  dm_lite_top UUT (
    .clk            (clk),
    .reset          (reset),
    .dmi_req        (dmi_req),
    .dmi_req_valid  (dmi_req_valid),
    .dmi_resp       (dmi_resp),
    .dmi_resp_valid (dmi_resp_valid)
  );

  dm_lite_checker chk (
    .clk            (clk),
    .reset          (reset),
    .dmi_req_valid  (dmi_req_valid),
    .dmi_resp       (dmi_resp),
    .dmi_resp_valid (dmi_resp_valid),
    .exp_en         (exp_en),
    .exp_id         (exp_id),
    .exp_step       (exp_step),
    .exp_op         (exp_op),
    .exp_data       (exp_data),
    .exp_mask       (exp_mask),
    .check_count    (check_count),
    .fail_count     (fail_count)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // ------------------------------------------------------------------
  // table building
  // ------------------------------------------------------------------
  task automatic add_read(input int id, input logic [6:0] addr,
                          input dm_lite_pkg::dmi_op_e op, input logic [31:0] data);
    step_t s;
    s = '{id: id,
          req: '{addr: addr, data: 32'd0, op: dm_lite_pkg::dmi_read},
          exp_op: op,
          exp_data: data,
          mask: (op == dm_lite_pkg::dmi_success) ? 32'hFFFF_FFFF : 32'd0,
          poll: 1'b0};
    steps.push_back(s);
  endtask

  task automatic add_write(input int id, input logic [6:0] addr, input logic [31:0] data,
                           input dm_lite_pkg::dmi_op_e op, input logic poll);
    step_t s;
    s = '{id: id,
          req: '{addr: addr, data: data, op: dm_lite_pkg::dmi_write},
          exp_op: op,
          exp_data: 32'd0,
          mask: 32'd0,        // write data is not checked
          poll: poll};
    steps.push_back(s);
  endtask

  task automatic build_table();
    // 1 reset values
    add_read(1, dm_lite_pkg::addr_dmstatus, dm_lite_pkg::dmi_success,
             stat_running | stat_version);
    add_read(1, dm_lite_pkg::addr_dmcontrol, dm_lite_pkg::dmi_success, 32'd0);
    // 2 halt, resume, deactivate
    add_write(2, dm_lite_pkg::addr_dmcontrol, ctrl_dmactive | ctrl_haltreq,
              dm_lite_pkg::dmi_success, 1'b0);
    add_read(2, dm_lite_pkg::addr_dmstatus, dm_lite_pkg::dmi_success,
             stat_halted | stat_version);
    add_read(2, dm_lite_pkg::addr_dmcontrol, dm_lite_pkg::dmi_success,
             ctrl_dmactive | ctrl_haltreq);
    add_write(2, dm_lite_pkg::addr_dmcontrol, ctrl_dmactive | ctrl_resumereq,
              dm_lite_pkg::dmi_success, 1'b0);
    add_read(2, dm_lite_pkg::addr_dmstatus, dm_lite_pkg::dmi_success,
             stat_running | stat_resumeack | stat_version);
    add_read(2, dm_lite_pkg::addr_dmcontrol, dm_lite_pkg::dmi_success, ctrl_dmactive);
    add_write(2, dm_lite_pkg::addr_dmcontrol, 32'd0, dm_lite_pkg::dmi_success, 1'b0);
    add_read(2, dm_lite_pkg::addr_dmstatus, dm_lite_pkg::dmi_success,
             stat_running | stat_version);
    add_read(2, dm_lite_pkg::addr_dmcontrol, dm_lite_pkg::dmi_success, 32'd0);
    // 3 single write, read back through read-on-address
    add_write(3, dm_lite_pkg::addr_sbaddress0, 32'h10, dm_lite_pkg::dmi_success, 1'b0);
    add_write(3, dm_lite_pkg::addr_sbdata0, words[0], dm_lite_pkg::dmi_success, 1'b1);
    add_write(3, dm_lite_pkg::addr_sbcs, sb_readonaddr, dm_lite_pkg::dmi_success, 1'b0);
    add_write(3, dm_lite_pkg::addr_sbaddress0, 32'h10, dm_lite_pkg::dmi_success, 1'b1);
    add_read(3, dm_lite_pkg::addr_sbdata0, dm_lite_pkg::dmi_success, words[0]);
    // 4 auto-increment burst
    add_write(4, dm_lite_pkg::addr_sbcs, sb_autoinc, dm_lite_pkg::dmi_success, 1'b0);
    add_write(4, dm_lite_pkg::addr_sbaddress0, 32'h40, dm_lite_pkg::dmi_success, 1'b0);
    for (int i = 0; i < 4; i++) begin
      add_write(4, dm_lite_pkg::addr_sbdata0, words[1 + i], dm_lite_pkg::dmi_success, 1'b1);
    end
    add_read(4, dm_lite_pkg::addr_sbaddress0, dm_lite_pkg::dmi_success, 32'h50);
    add_write(4, dm_lite_pkg::addr_sbcs, sb_readonaddr | sb_autoinc,
              dm_lite_pkg::dmi_success, 1'b0);
    for (int i = 0; i < 4; i++) begin
      add_write(4, dm_lite_pkg::addr_sbaddress0, 32'h40 + 32'(4 * i),
                dm_lite_pkg::dmi_success, 1'b1);
      add_read(4, dm_lite_pkg::addr_sbdata0, dm_lite_pkg::dmi_success, words[1 + i]);
      add_read(4, dm_lite_pkg::addr_sbaddress0, dm_lite_pkg::dmi_success,
               32'h44 + 32'(4 * i));
    end
    add_read(4, dm_lite_pkg::addr_sbcs, dm_lite_pkg::dmi_success,
             sb_readonaddr | sb_autoinc | sb_access32);
    // 5 second sbdata0 write lands inside the busy window
    add_write(5, dm_lite_pkg::addr_sbcs, 32'd0, dm_lite_pkg::dmi_success, 1'b0);
    add_write(5, dm_lite_pkg::addr_sbaddress0, 32'h80, dm_lite_pkg::dmi_success, 1'b0);
    add_write(5, dm_lite_pkg::addr_sbdata0, words[5], dm_lite_pkg::dmi_success, 1'b0);
    add_write(5, dm_lite_pkg::addr_sbdata0, words[6], dm_lite_pkg::dmi_busy, 1'b1);
    add_read(5, dm_lite_pkg::addr_sbcs, dm_lite_pkg::dmi_success, sb_busyerror | sb_access32);
    add_write(5, dm_lite_pkg::addr_sbcs, sb_readonaddr, dm_lite_pkg::dmi_success, 1'b0);
    add_write(5, dm_lite_pkg::addr_sbaddress0, 32'h80, dm_lite_pkg::dmi_success, 1'b1);
    add_read(5, dm_lite_pkg::addr_sbdata0, dm_lite_pkg::dmi_success, words[5]);
    add_write(5, dm_lite_pkg::addr_sbcs, sb_busyerror, dm_lite_pkg::dmi_success, 1'b0);
    add_read(5, dm_lite_pkg::addr_sbcs, dm_lite_pkg::dmi_success, sb_access32);
    // 6 unmapped
    add_read(6, addr_unmapped, dm_lite_pkg::dmi_failed, 32'd0);
    add_write(6, addr_unmapped, 32'h1234_5678, dm_lite_pkg::dmi_failed, 1'b0);
  endtask

  // ------------------------------------------------------------------
  // DMI driver, called on a falling edge
  // ------------------------------------------------------------------
  task automatic send_request(input dm_lite_pkg::dmi_req_t req, input logic check_it,
                              input step_t s, input int idx, output logic got);
    int n;
    dmi_req       = req;
    dmi_req_valid = 1'b1;
    exp_en        = check_it;
    exp_id        = s.id;
    exp_step      = 16'(idx);
    exp_op        = s.exp_op;
    exp_data      = s.exp_data;
    exp_mask      = s.mask;
    @(negedge clk);
    dmi_req_valid = 1'b0;
    got = 1'b0;
    for (n = 0; n < resp_timeout && !got; n++) begin
      if (dmi_resp_valid) begin
        got = 1'b1;
      end else begin
        @(negedge clk);
      end
    end
    if (!got) begin
      timeouts++;
      $display("test %0d step %0d: no DMI response within %0d cycles",
               s.id, idx, resp_timeout);
    end
    @(negedge clk);  // idle cycle before the next request
  endtask

  task automatic poll_idle(input step_t s, input int idx);
    dm_lite_pkg::dmi_req_t rd;
    logic                  got;
    logic                  idle;
    rd   = '{addr: dm_lite_pkg::addr_sbcs, data: 32'd0, op: dm_lite_pkg::dmi_read};
    idle = 1'b0;
    for (int n = 0; n < poll_limit && !idle; n++) begin
      send_request(rd, 1'b0, s, idx, got);
      idle = got && ((dmi_resp.data & sb_busy) == 32'd0);
    end
    if (!idle) begin
      stalls++;
      $display("test %0d step %0d: sbbusy never cleared after %0d sbcs reads",
               s.id, idx, poll_limit);
    end
  endtask

  // ------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------
  initial begin
    logic got;
    reset         = 1'b1;
    dmi_req       = '0;
    dmi_req_valid = 1'b0;
    exp_en        = 1'b0;
    exp_id        = 0;
    exp_step      = '0;
    exp_op        = dm_lite_pkg::dmi_nop;
    exp_data      = '0;
    exp_mask      = '0;
    timeouts      = 0;
    stalls        = 0;
    words[0]      = $urandom(rand_seed);  // first draw seeds the generator
    for (int i = 1; i < 7; i++) begin
      words[i] = $urandom;
    end
    build_table();

    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    for (int i = 0; i < steps.size(); i++) begin
      send_request(steps[i].req, 1'b1, steps[i], i, got);
      if (got && steps[i].poll) begin
        poll_idle(steps[i], i);
      end
    end
    repeat (2) @(negedge clk);  // let the last compare settle

    $display("summary: %0d of %0d steps checked, %0d mismatches, %0d timeouts, %0d stalls",
             check_count, steps.size(), fail_count, timeouts, stalls);
    if (fail_count == 0 && timeouts == 0 && stalls == 0 && check_count == steps.size()) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
